//--- common/board_pkg.sv
`default_nettype none

package board_pkg;

    //--------------------------------------------------
    // board geometry
    //--------------------------------------------------

    // two push buttons on the board
    localparam int w_key = 2;

    // six user leds on the board
    localparam int w_led = 6;

    //--------------------------------------------------
    // reset and pacing
    //--------------------------------------------------

    // lab reset stays low this many cycles after rst_n rises
    localparam int reset_hold_cycles = 8;
    localparam int w_hold_cnt        = $clog2(reset_hold_cycles + 1);

    // board clock cycles between slow ticks, short for simulation
    localparam int slow_period_cycles = 16;
    localparam int w_slow_cnt         = $clog2(slow_period_cycles);

    // one-hot light starts on lab led 0
    localparam logic [w_led-1:0] led_reset_pattern = w_led'(1);

    //--------------------------------------------------
    // lab types
    //--------------------------------------------------

    // one-cycle press strobes, bit 0 from lab key 0, bit 1 from lab key 1
    typedef struct packed {
        logic reverse_dir;
        logic toggle_run;
    } key_press_t;

    // rotating light state, 8 bits in total
    typedef struct packed {
        logic             running;
        logic             dir_up;
        logic [w_led-1:0] pattern;
    } lab_state_t;

    // state right after reset: running, moving toward the top led
    localparam lab_state_t lab_state_reset = '{
        running: 1'b1,
        dir_up:  1'b1,
        pattern: led_reset_pattern
    };

endpackage

`default_nettype wire

//--- rtl/reset_stretcher.sv
`default_nettype none

module reset_stretcher
(
    input  wire  clk,
    input  wire  rst_n,
    output logic lab_rst_n
);

    import board_pkg::*;

    // counts clock edges since rst_n was first sampled high
    logic [w_hold_cnt-1:0] hold_cnt;

    // count has reached the hold length
    logic                  hold_done;

    assign hold_done = (hold_cnt == w_hold_cnt'(reset_hold_cycles));

    //--------------------------------------------------
    // power-up style reset imitation
    //--------------------------------------------------

    // any low sample of rst_n restarts the whole hold period,
    // so even a one-cycle external pulse gives a full lab reset
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            hold_cnt  <= '0;
            lab_rst_n <= 1'b0;
        end
        else
        begin
            // saturate once the hold length is reached
            if (!hold_done)
                hold_cnt <= hold_cnt + 1'b1;

            // lab reset releases on the edge that sees the full count
            lab_rst_n <= hold_done;
        end
    end

endmodule

`default_nettype wire

//--- rtl/slow_tick_gen.sv
`default_nettype none

module slow_tick_gen
(
    input  wire  clk,
    input  wire  rst_n,
    output logic slow_tick
);

    import board_pkg::*;

    // free-running divider count
    logic [w_slow_cnt-1:0] div_cnt;

    // last count of a period
    logic                  div_wrap;

    assign div_wrap = (div_cnt == w_slow_cnt'(slow_period_cycles - 1));

    //--------------------------------------------------
    // clock divider
    //--------------------------------------------------

    // stands in for the 1 hz slow clock of the board,
    // but as a one-cycle enable in the clk domain
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            div_cnt   <= '0;
            slow_tick <= 1'b0;
        end
        else if (div_wrap)
        begin
            // wrap and pulse, one period after the previous pulse
            div_cnt   <= '0;
            slow_tick <= 1'b1;
        end
        else
        begin
            div_cnt   <= div_cnt + 1'b1;
            slow_tick <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- lab/key_press_detector.sv
`default_nettype none

module key_press_detector
(
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire  [board_pkg::w_key-1:0] key,
    output board_pkg::key_press_t       press
);

    import board_pkg::*;

    //--------------------------------------------------
    // synchronizer and edge detect state
    //--------------------------------------------------

    // first synchronizer stage, may go metastable
    logic [w_key-1:0] key_meta;

    // second synchronizer stage, safe to use
    logic [w_key-1:0] key_sync;

    // synchronized value one cycle earlier
    logic [w_key-1:0] key_prev;

    // registered rising edge of each key
    logic [w_key-1:0] key_rise;

    // timeline for a key that first samples high on edge n:
    // key_sync high after n+1, key_rise after n+2, press after n+3
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            key_meta <= '0;
            key_sync <= '0;
            key_prev <= '0;
            key_rise <= '0;
            press    <= '0;
        end
        else
        begin
            // two-flop synchronizer for the asynchronous buttons
            key_meta <= key;
            key_sync <= key_meta;

            // rising edge only, a held key sees key_prev high
            key_prev <= key_sync;
            key_rise <= key_sync & ~key_prev;

            // pack the strobes by meaning
            press.toggle_run  <= key_rise[0];
            press.reverse_dir <= key_rise[1];
        end
    end

    // a new strobe on the same key needs a release in between,
    // since key_prev must go low again before key_rise can rise
    // each strobe lasts exactly one cycle and is never held back

endmodule

`default_nettype wire

//--- lab/lab_top.sv
`default_nettype none

module lab_top
(
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         slow_tick,
    input  wire  [board_pkg::w_key-1:0] key,
    output logic [board_pkg::w_led-1:0] led
);

    import board_pkg::*;

    //--------------------------------------------------
    // key presses
    //--------------------------------------------------

    // one-cycle strobes, key 0 pauses or resumes, key 1 reverses
    key_press_t press;

    key_press_detector i_key_press_detector
    (
        .clk   ( clk   ),
        .rst_n ( rst_n ),
        .key   ( key   ),
        .press ( press )
    );

    //--------------------------------------------------
    // rotating light state
    //--------------------------------------------------

    // current and next run flag, direction and one-hot pattern
    lab_state_t state;
    lab_state_t state_next;

    // move the lit bit by one place with wrap around
    // up means toward the msb, lab led 5
    function automatic logic [w_led-1:0] rotate_one
    (
        input logic [w_led-1:0] pattern,
        input logic             up
    );
        logic [w_led-1:0] rotated;

        if (up)
            rotated = {pattern[w_led-2:0], pattern[w_led-1]};
        else
            rotated = {pattern[0], pattern[w_led-1:1]};

        return rotated;
    endfunction

    always_comb
    begin
        state_next = state;

        // rotation looks only at the old flags, so a press that
        // lands on a tick cycle takes effect from the next tick
        if (slow_tick && state.running)
            state_next.pattern = rotate_one(state.pattern, state.dir_up);

        // pause or resume
        if (press.toggle_run)
            state_next.running = ~state.running;

        // flip direction
        if (press.reverse_dir)
            state_next.dir_up = ~state.dir_up;
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            state <= lab_state_reset;
        else
            state <= state_next;
    end

    //--------------------------------------------------
    // led output
    //--------------------------------------------------

    // active high lab leds, one cycle after the tick that moved them
    assign led = state.pattern;

endmodule

`default_nettype wire

//--- rtl/board_specific_top.sv
`default_nettype none

module board_specific_top
(
    input  wire                         CLK,
    input  wire                         rst_n,
    input  wire  [board_pkg::w_key-1:0] KEY,
    output wire  [board_pkg::w_led-1:0] LED
);

    import board_pkg::*;

    //--------------------------------------------------
    // internal nets
    //--------------------------------------------------

    // board oscillator used directly as the lab clock
    wire             clk = CLK;

    // stretched reset for everything behind the pins
    wire             lab_rst_n;

    // one-cycle pacing strobe for the lab
    wire             slow_tick;

    // active high, lab bit order
    wire [w_key-1:0] lab_key;
    wire [w_led-1:0] lab_led;

    //--------------------------------------------------
    // pin polarity and bit order
    //--------------------------------------------------

    // buttons pull low when pressed, and the board numbers
    // them the other way round from the lab
    // lab key 0 comes from KEY[1], lab key 1 from KEY[0]
    for (genvar i = 0; i < w_key; i++)
    begin : g_key_swap
        assign lab_key[i] = ~KEY[w_key - 1 - i];
    end

    // leds light on a low pin, and pin order is mirrored
    // so lab led i drives LED[5 - i]
    for (genvar i = 0; i < w_led; i++)
    begin : g_led_swap
        assign LED[w_led - 1 - i] = ~lab_led[i];
    end

    //--------------------------------------------------
    // reset
    //--------------------------------------------------

    // two-button board has no spare key for reset, so the
    // external reset is widened into a power-up style pulse
    reset_stretcher i_reset_stretcher
    (
        .clk       ( clk       ),
        .rst_n     ( rst_n     ),
        .lab_rst_n ( lab_rst_n )
    );

    //--------------------------------------------------
    // slow tick
    //--------------------------------------------------

    // enable strobe in the clk domain, no derived clock
    slow_tick_gen i_slow_tick_gen
    (
        .clk       ( clk       ),
        .rst_n     ( lab_rst_n ),
        .slow_tick ( slow_tick )
    );

    //--------------------------------------------------
    // lab design
    //--------------------------------------------------

    // while lab_rst_n is low the lab holds led 0 lit,
    // which shows on the pins as LED = 011111
    lab_top i_lab_top
    (
        .clk       ( clk       ),
        .rst_n     ( lab_rst_n ),
        .slow_tick ( slow_tick ),
        .key       ( lab_key   ),
        .led       ( lab_led   )
    );

endmodule

`default_nettype wire

//--- tb/board_assertions.sv
`default_nettype none

module board_assertions
(
    input wire                        clk,
    input wire                        rst_n,
    input wire board_pkg::lab_state_t state,
    input wire board_pkg::key_press_t press
);

    import board_pkg::*;

    //--------------------------------------------------
    // lab state properties
    //--------------------------------------------------

    // exactly one lab led lit once out of reset
    pattern_one_hot: assert property (@(posedge clk) disable iff (rst_n !== 1'b1)
        $onehot(state.pattern))
        else $error("lab pattern is not one-hot: %b", state.pattern);

    // press strobes last one cycle only
    toggle_single: assert property (@(posedge clk) disable iff (rst_n !== 1'b1)
        press.toggle_run |=> !press.toggle_run)
        else $error("toggle_run strobe held for two cycles");

    reverse_single: assert property (@(posedge clk) disable iff (rst_n !== 1'b1)
        press.reverse_dir |=> !press.reverse_dir)
        else $error("reverse_dir strobe held for two cycles");

    // synchronous reset gives a running light on lab led 0 that moves up
    reset_values: assert property (@(posedge clk) !rst_n |=>
        (state.running === 1'b1 && state.dir_up === 1'b1 && state.pattern === w_led'(1)))
        else $error("lab state left its reset values during reset");

endmodule

bind lab_top board_assertions i_board_assertions
(
    .clk   ( clk   ),
    .rst_n ( rst_n ),
    .state ( state ),
    .press ( press )
);

`default_nettype wire

//--- tb/board_checker.sv
`default_nettype none

module board_checker
(
    input wire                         clk,
    input wire [board_pkg::w_led-1:0]  led
);

    import board_pkg::*;

    // test results so far
    int pass_count;
    int fail_count;

    // LED pins as seen on the last rising edge
    logic [w_led-1:0] led_seen;

    initial
    begin
        pass_count = 0;
        fail_count = 0;
    end

    always @(posedge clk)
    begin
        led_seen <= led;
    end

    //--------------------------------------------------
    // per-test reporting
    //--------------------------------------------------

    // compare the sampled pins with the expected pins
    task automatic check_led(input string name, input logic [w_led-1:0] exp_led);
        if (led_seen === exp_led)
        begin
            pass_count++;
            $display("Pass %s LED %b", name, led_seen);
        end
        else
        begin
            fail_count++;
            $display("Fail %s expected %b actual %b", name, exp_led, led_seen);
        end
    endtask

    // a test that could not reach its check
    task automatic record_lost(input string name, input string what);
        fail_count++;
        $display("Error in %s: %s", name, what);
    endtask

    task automatic report_counts();
        $display("counts: %0d passed, %0d failed, %0d run",
                 pass_count, fail_count, pass_count + fail_count);
    endtask

endmodule

`default_nettype wire

//--- tb/tb_board_top.sv
`default_nettype none

module tb_board_top;

    import board_pkg::*;

    logic             clk;
    logic             rst_n;
    logic [w_key-1:0] key;
    wire  [w_led-1:0] led;

    board_specific_top dut
    (
        .CLK   ( clk   ),
        .rst_n ( rst_n ),
        .KEY   ( key   ),
        .LED   ( led   )
    );

    board_checker chk
    (
        .clk ( clk ),
        .led ( led )
    );

    // period 8
    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    //--------------------------------------------------
    // stimulus helpers
    //--------------------------------------------------

    // keys are active low, a press lasts 6 cycles
    task automatic press_key(input int pin);
        key[pin] = 1'b0;
        repeat (6) @(negedge clk);
        key[pin] = 1'b1;
    endtask

    task automatic wait_lab_reset(output bit ok);
        int cycles;
        cycles = 0;
        do
        begin
            @(negedge clk);
            cycles++;
        end
        while (dut.lab_rst_n !== 1'b1 && cycles < 4 * reset_hold_cycles);
        ok = (dut.lab_rst_n === 1'b1);
    endtask

    // count slow ticks, each one with its own cycle limit
    task automatic wait_ticks(input int n, output bit ok);
        int cycles;
        ok = 1'b1;
        for (int t = 0; t < n; t++)
        begin
            cycles = 0;
            do
            begin
                @(negedge clk);
                cycles++;
            end
            while (dut.slow_tick !== 1'b1 && cycles < 2 * slow_period_cycles);
            if (dut.slow_tick !== 1'b1)
            begin
                ok = 1'b0;
                return;
            end
        end
    endtask

    task automatic skip_line(input int fd);
        int c;
        c = $fgetc(fd);
        while (c != "\n" && c != -1)
            c = $fgetc(fd);
    endtask

    task automatic run_test(input string name, input string act, input int n_ticks,
                            input logic [w_led-1:0] exp_led, output bit ok);
        bit held;
        held = 1'b0;
        ok   = 1'b1;
        if (act == "press0")
            press_key(0);
        else if (act == "press1")
            press_key(1);
        else if (act == "hold0")
        begin
            // released only after the ticks are counted
            key[0] = 1'b0;
            held   = 1'b1;
        end
        else if (act != "none")
        begin
            chk.record_lost(name, "unknown key action in the vectors file");
            return;
        end
        wait_ticks(n_ticks, ok);
        if (!ok)
        begin
            key = '1;
            chk.record_lost(name, "timed out waiting for a slow tick");
            return;
        end
        if (held)
            key[0] = 1'b1;
        // pins settle one cycle after the tick
        repeat (2) @(negedge clk);
        chk.check_led(name, exp_led);
    endtask

    //--------------------------------------------------
    // main sequence
    //--------------------------------------------------

    initial
    begin
        int               fd;
        int               code;
        string            name;
        string            act;
        int               n_ticks;
        logic [w_led-1:0] exp_led;
        bit               ok;

        key   = '1;
        rst_n = 1'b0;
        repeat (4) @(negedge clk);
        rst_n = 1'b1;

        wait_lab_reset(ok);
        if (!ok)
            chk.record_lost("reset", "lab reset never released");

        fd = $fopen("tb/board_vectors.txt", "r");
        if (fd == 0)
            chk.record_lost("vectors", "could not open tb/board_vectors.txt");
        else
        begin
            code = $fscanf(fd, "%s", name);
            while (code == 1 && ok)
            begin
                if (name[0] == "#")
                    skip_line(fd);
                else if ($fscanf(fd, "%s %d %b", act, n_ticks, exp_led) != 3)
                begin
                    chk.record_lost(name, "badly formed line in the vectors file");
                    ok = 1'b0;
                end
                else
                    run_test(name, act, n_ticks, exp_led, ok);
                code = $fscanf(fd, "%s", name);
            end
            $fclose(fd);
        end

        chk.report_counts();
        if (chk.fail_count == 0 && chk.pass_count > 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb/board_vectors.txt
# columns: test name, key action (none press0 press1 hold0), slow ticks to wait,
# expected LED pins as binary, LED[5] first
reset_pattern   none    0  011111
rotate_one      none    1  101111
rotate_wrap     none    7  110111
pause           press1  3  110111
resume          press1  2  111101
reverse         press0  1  111011
reverse_wrap    none    4  111110
hold_key        hold0   3  110111
after_hold      none    2  111101
reverse_back    press0  1  111011
pause_again     press1  2  111011

//--- tb.f
common/board_pkg.sv
rtl/reset_stretcher.sv
rtl/slow_tick_gen.sv
lab/key_press_detector.sv
lab/lab_top.sv
rtl/board_specific_top.sv
tb/board_assertions.sv
tb/board_checker.sv
tb/tb_board_top.sv
